//--- Bender.yml
package:
  name: cfg_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/cfg_ctrl_pkg.sv
      - source/cfg_arbiter.sv
      - source/cfg_master_mux.sv
      - source/cfg_target_route.sv
      - source/cfg_local_regs.sv
      - source/cfg_ctrl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/cfg_target_model.sv
      - dv/cfg_ctrl_tb.sv

//--- dv/cfg_ctrl_tb.sv
`include "cfg_ctrl_config.svh"

`default_nettype none

module cfg_ctrl_tb
	import cfg_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_period      = 8;
	localparam int num_tests       = 5;
	localparam int cycles_per_test = 200;
	localparam int rand_seed       = 59249;
	localparam logic [`CFG_DATA_W-1:0] tag_base   = 32'hA000_0000;
	localparam logic [`CFG_ADDR_W-1:0] local_addr = {`CFG_PAGE_LOCAL, 12'h000};
	localparam logic [`CFG_ADDR_W-1:0] sub_addr   = 32'h3000_7000;

	logic                      axi_clk;
	logic                      axi_reset_n;
	wb_req_t                   wb_req;
	wb_rsp_t                   wb_rsp;
	aa_req_t                   aa_req;
	aa_rsp_t                   aa_rsp;
	axil_req_t                 m_req;
	rd_resp_t                  tgt_rd_resp [`CFG_NUM_TGT];
	wr_resp_t                  tgt_wr_resp [`CFG_NUM_TGT];
	tgt_en_t                   tgt_en;
	logic [`CFG_PRJ_SEL_W-1:0] user_prj_sel;
	// last value written to the project select register
	logic [`CFG_PRJ_SEL_W-1:0] prj_sel_exp;

	cfg_ctrl_top uut (
		.axi_clk        (axi_clk),
		.axi_reset_n    (axi_reset_n),
		.wb_req_i       (wb_req),
		.wb_rsp_o       (wb_rsp),
		.aa_req_i       (aa_req),
		.aa_rsp_o       (aa_rsp),
		.m_req_o        (m_req),
		.tgt_rd_resp_i  (tgt_rd_resp),
		.tgt_wr_resp_i  (tgt_wr_resp),
		.tgt_en_o       (tgt_en),
		.user_prj_sel_o (user_prj_sel)
	);

	cfg_target_model u_targets (
		.rd_resp_o (tgt_rd_resp),
		.wr_resp_o (tgt_wr_resp)
	);

	initial begin
		axi_clk = 1'b0;
		forever #(clk_period / 2) axi_clk = ~axi_clk;
	end

	// ------------------------------
	// reporting and checks
	// ------------------------------
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else fail_now($sformatf("FAIL t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got));
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond === 1'b1)
		else fail_now(msg);
	endtask

	// page of a target index in la aa up is as order
	function automatic logic [19:0] page_of(input int idx);
		case (idx)
			0:       return `CFG_PAGE_LA;
			1:       return `CFG_PAGE_AA;
			2:       return `CFG_PAGE_UP;
			3:       return `CFG_PAGE_IS;
			default: return `CFG_PAGE_AS;
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge axi_clk);
	endtask

	// ------------------------------
	// bus transfers entered on a falling edge
	// ------------------------------
	task automatic wb_transfer(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
		input logic [3:0] sel, output logic [31:0] rdata, output logic [4:0] en_seen,
		output time done_t);
		logic acked;
		acked   = 1'b0;
		en_seen = '0;
		wb_req  = '{adr: adr, wdata: wdata, sel: sel, cyc: 1'b1, stb: 1'b1, we: we};
		while (!acked) begin
			@(negedge axi_clk);
			en_seen = en_seen | tgt_en;
			acked   = wb_rsp.ack;
		end
		rdata  = wb_rsp.rdata;
		done_t = $time;
		// master side carries the granted wishbone cycle
		check_value("m_req_o.wvalid", 32'(m_req.wvalid), 32'(we));
		check_value("m_req_o.rready", 32'(m_req.rready), 32'(!we));
		if (we) begin
			check_value("m_req_o.awaddr", 32'(m_req.awaddr), 32'(adr[`CFG_M_ADDR_W-1:0]));
			check_value("m_req_o.wdata", m_req.wdata, wdata);
			check_value("m_req_o.wstrb", 32'(m_req.wstrb), 32'(sel));
		end else begin
			check_value("m_req_o.araddr", 32'(m_req.araddr), 32'(adr[`CFG_M_ADDR_W-1:0]));
		end
		// ack completes on the next rising edge so release after it
		@(negedge axi_clk);
		wb_req = '0;
	endtask

	task automatic aa_read(input logic [31:0] addr, output logic [31:0] rdata,
		output logic [4:0] en_seen, output time done_t);
		logic got_rvalid;
		got_rvalid     = 1'b0;
		en_seen        = '0;
		aa_req.araddr  = addr;
		aa_req.arvalid = 1'b1;
		aa_req.rready  = 1'b1;
		while (!got_rvalid) begin
			@(negedge axi_clk);
			en_seen    = en_seen | tgt_en;
			got_rvalid = aa_rsp.rvalid;
		end
		rdata  = aa_rsp.rdata;
		done_t = $time;
		// bridge read passes straight to the master
		check_value("aa_rsp_o.arready", 32'(aa_rsp.arready), 32'h1);
		check_value("m_req_o.arvalid", 32'(m_req.arvalid), 32'h1);
		check_value("m_req_o.rready", 32'(m_req.rready), 32'h1);
		check_value("m_req_o.araddr", 32'(m_req.araddr), 32'(addr[`CFG_M_ADDR_W-1:0]));
		@(negedge axi_clk);
		aa_req = '0;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic local_write_read();
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [4:0]  en_seen;
		time         done_t;
		wdata = $urandom;
		wb_transfer(1'b1, local_addr, wdata, 4'($urandom) | 4'b0001, rdata, en_seen, done_t);
		prj_sel_exp = wdata[`CFG_PRJ_SEL_W-1:0];
		idle_cycles(2);
		wb_transfer(1'b0, local_addr, '0, 4'hF, rdata, en_seen, done_t);
		check_value("wb_rsp.rdata", rdata, 32'(prj_sel_exp));
		check_value("user_prj_sel_o", 32'(user_prj_sel), 32'(prj_sel_exp));
		idle_cycles(2);
	endtask

	task automatic local_write_masked();
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [4:0]  en_seen;
		time         done_t;
		// low bits inverted so any update shows
		wdata = $urandom;
		wdata[`CFG_PRJ_SEL_W-1:0] = ~prj_sel_exp;
		wb_transfer(1'b1, local_addr + 32'h4, wdata, 4'hF, rdata, en_seen, done_t);
		idle_cycles(2);
		check_value("user_prj_sel_o", 32'(user_prj_sel), 32'(prj_sel_exp));
		wb_transfer(1'b1, local_addr, wdata, 4'hE, rdata, en_seen, done_t);
		idle_cycles(2);
		check_value("user_prj_sel_o", 32'(user_prj_sel), 32'(prj_sel_exp));
	endtask

	task automatic target_reads();
		logic [31:0] rdata;
		logic [4:0]  en_seen;
		time         done_t;
		for (int i = 0; i < `CFG_NUM_TGT; i++) begin
			aa_read({page_of(i), 10'($urandom), 2'b00}, rdata, en_seen, done_t);
			check_value("aa_rsp.rdata", rdata, tag_base + i);
			check_true(en_seen[i], $sformatf("tgt_en_o bit %0d never rose during its read", i));
			idle_cycles(2);
		end
	endtask

	task automatic sub_range_reads();
		logic [31:0] rdata;
		logic [4:0]  en_seen;
		time         done_t;
		aa_read(sub_addr, rdata, en_seen, done_t);
		check_value("aa_rsp.rdata", rdata, '1);
		check_true(en_seen == '0, "a target enable rose on a bridge sub-range read");
		idle_cycles(2);
		wb_transfer(1'b0, sub_addr, '0, 4'hF, rdata, en_seen, done_t);
		check_value("wb_rsp.rdata", rdata, '1);
		check_true(en_seen == '0, "a target enable rose on a wishbone sub-range read");
		idle_cycles(2);
		// sub-range write is dropped
		wb_transfer(1'b1, sub_addr, 32'(~prj_sel_exp), 4'hF, rdata, en_seen, done_t);
		idle_cycles(2);
		check_value("user_prj_sel_o", 32'(user_prj_sel), 32'(prj_sel_exp));
	endtask

	task automatic same_cycle_requests();
		logic [31:0] wb_rdata;
		logic [31:0] aa_rdata;
		logic [4:0]  wb_en;
		logic [4:0]  aa_en;
		time         wb_done;
		time         aa_done;
		fork
			wb_transfer(1'b0, local_addr, '0, 4'hF, wb_rdata, wb_en, wb_done);
			aa_read({page_of(4), 12'h010}, aa_rdata, aa_en, aa_done);
		join
		check_value("wb_rsp.rdata", wb_rdata, 32'(prj_sel_exp));
		check_value("aa_rsp.rdata", aa_rdata, tag_base + 4);
		check_true(wb_done < aa_done, "wishbone ack did not come before the bridge rvalid");
		check_true(wb_en == '0, "a target enable rose on the wishbone local read");
		check_true(aa_en[4], "tgt_en_o bit 4 never rose during the bridge read");
		idle_cycles(2);
	endtask

	// ------------------------------
	// main sequence and watchdog
	// ------------------------------
	initial begin
		void'($urandom(rand_seed));
		axi_reset_n = 1'b0;
		wb_req      = '0;
		aa_req      = '0;
		prj_sel_exp = '0;
		repeat (2) @(posedge axi_clk);
		@(negedge axi_clk);
		axi_reset_n = 1'b1;
		@(negedge axi_clk);
		check_value("user_prj_sel_o", 32'(user_prj_sel), 32'h0);
		check_value("wb_rsp_o.ack", 32'(wb_rsp.ack), 32'h0);
		check_value("tgt_en_o", tgt_en, 32'h0);
		check_value("m_req_o.awvalid", 32'(m_req.awvalid), 32'h0);
		check_value("m_req_o.wvalid", 32'(m_req.wvalid), 32'h0);
		check_value("m_req_o.arvalid", 32'(m_req.arvalid), 32'h0);
		local_write_read();
		local_write_masked();
		target_reads();
		sub_range_reads();
		same_cycle_requests();
		$display("TEST PASS");
		$finish;
	end

	initial begin
		#(num_tests * cycles_per_test * clk_period);
		fail_now("watchdog expired before all tests finished");
	end

endmodule

`default_nettype wire

//--- dv/cfg_target_model.sv
`include "cfg_ctrl_config.svh"

`default_nettype none

module cfg_target_model
	import cfg_ctrl_pkg::*;
(
	output rd_resp_t rd_resp_o [`CFG_NUM_TGT],
	output wr_resp_t wr_resp_o [`CFG_NUM_TGT]
);

	timeunit 1ns;
	timeprecision 100ps;

	// read data tag, target index in the low bits
	localparam logic [`CFG_DATA_W-1:0] tag_base = 32'hA000_0000;

	// ------------------------------
	// five always-ready targets
	// ------------------------------
	for (genvar i = 0; i < `CFG_NUM_TGT; i++) begin : g_tgt
		// reads answer in the cycle they are selected
		assign rd_resp_o[i] = '{arready: 1'b1, rvalid: 1'b1, rdata: tag_base + i};
		assign wr_resp_o[i] = '{awready: 1'b1, wready: 1'b1};
	end

endmodule

`default_nettype wire

//--- source/cfg_arbiter.sv
`default_nettype none

module cfg_arbiter
	import cfg_ctrl_pkg::*;
(
	input  wire     axi_clk,
	input  wire     axi_reset_n,
	input  wire     wb_req_t wb_req_i,
	input  wire     aa_req_t aa_req_i,
	input  wire     aa_wready_i,
	input  wire     aa_rvalid_i,
	output logic    grant_wb_o,
	output logic    grant_aa_o
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_GRANT_WB,
		ARB_GRANT_AA
	} arb_state_e;

	arb_state_e state_q;
	logic       wb_req;
	logic       aa_rd_req_q;
	logic       aa_wr_req_q;
	logic       aa_req;

	// wishbone holds cyc and stb until ack
	assign wb_req = wb_req_i.cyc & wb_req_i.stb;

	// ------------------------------
	// bridge request flags
	// ------------------------------
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			aa_rd_req_q <= 1'b0;
			aa_wr_req_q <= 1'b0;
		end else begin
			// read pending from arvalid until rvalid
			if (aa_req_i.arvalid & !aa_rd_req_q)
				aa_rd_req_q <= 1'b1;
			else if (aa_rvalid_i)
				aa_rd_req_q <= 1'b0;
			// write pending from awvalid+wvalid until wready
			if (aa_req_i.awvalid & aa_req_i.wvalid & !aa_wr_req_q)
				aa_wr_req_q <= 1'b1;
			else if (aa_wready_i)
				aa_wr_req_q <= 1'b0;
		end
	end

	assign aa_req = aa_rd_req_q | aa_wr_req_q;

	// grant fsm, wishbone first
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state_q <= ARB_IDLE;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (wb_req)
						state_q <= ARB_GRANT_WB;
					else if (aa_req)
						state_q <= ARB_GRANT_AA;
				end
				// hold until the granted request drops
				ARB_GRANT_WB: if (!wb_req) state_q <= ARB_IDLE;
				ARB_GRANT_AA: if (!aa_req) state_q <= ARB_IDLE;
				default: state_q <= ARB_IDLE;
			endcase
		end
	end

	assign grant_wb_o = (state_q == ARB_GRANT_WB);
	assign grant_aa_o = (state_q == ARB_GRANT_AA);

endmodule

`default_nettype wire

//--- source/cfg_ctrl_config.svh
`ifndef CFG_CTRL_CONFIG_SVH
`define CFG_CTRL_CONFIG_SVH

`default_nettype none

// bus widths
`define CFG_DATA_W    32
`define CFG_ADDR_W    32
// master address keeps the low 15 bits only
`define CFG_M_ADDR_W  15
`define CFG_STRB_W    4

// 4 KB pages, page number starts here
`define CFG_PAGE_LSB  12

// ------------------------------
// page map of the targets
// ------------------------------
`define CFG_PAGE_UP     20'h30000
`define CFG_PAGE_LA     20'h30001
`define CFG_PAGE_AA     20'h30002
`define CFG_PAGE_IS     20'h30003
`define CFG_PAGE_AS     20'h30004
// local register page
`define CFG_PAGE_LOCAL  20'h30005

// sub range, answered locally with all ones
`define CFG_SUB_FIRST   20'h30006
`define CFG_SUB_LAST    20'h3FFFF

// project select register
`define CFG_PRJ_SEL_W  5
`define CFG_NUM_TGT    5

`default_nettype wire

`endif

//--- source/cfg_ctrl_pkg.sv
`include "cfg_ctrl_config.svh"

`default_nettype none

package cfg_ctrl_pkg;

	// ------------------------------
	// wishbone slave side
	// ------------------------------
	typedef struct packed {
		logic [`CFG_ADDR_W-1:0] adr;
		logic [`CFG_DATA_W-1:0] wdata;
		logic [`CFG_STRB_W-1:0] sel;
		logic                   cyc;
		logic                   stb;
		logic                   we;
	} wb_req_t;

	typedef struct packed {
		logic                   ack;
		logic [`CFG_DATA_W-1:0] rdata;
	} wb_rsp_t;

	// ------------------------------
	// bridge axi-lite side
	// ------------------------------
	typedef struct packed {
		logic                   awvalid;
		logic [`CFG_ADDR_W-1:0] awaddr;
		logic                   wvalid;
		logic [`CFG_DATA_W-1:0] wdata;
		logic [`CFG_STRB_W-1:0] wstrb;
		logic                   arvalid;
		logic [`CFG_ADDR_W-1:0] araddr;
		logic                   rready;
	} aa_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   arready;
		logic                   rvalid;
		logic [`CFG_DATA_W-1:0] rdata;
	} aa_rsp_t;

	// master port towards the targets
	typedef struct packed {
		logic                     awvalid;
		logic [`CFG_M_ADDR_W-1:0] awaddr;
		logic                     wvalid;
		logic [`CFG_DATA_W-1:0]   wdata;
		logic [`CFG_STRB_W-1:0]   wstrb;
		logic                     arvalid;
		logic [`CFG_M_ADDR_W-1:0] araddr;
		logic                     rready;
	} axil_req_t;

	// per-target responses, read and write channel
	typedef struct packed {
		logic                   arready;
		logic                   rvalid;
		logic [`CFG_DATA_W-1:0] rdata;
	} rd_resp_t;

	typedef struct packed {
		logic awready;
		logic wready;
	} wr_resp_t;

	// decoded page
	typedef enum logic [2:0] {
		TGT_NONE,
		TGT_LA,
		TGT_AA,
		TGT_UP,
		TGT_IS,
		TGT_AS,
		TGT_LOCAL,
		TGT_SUB
	} tgt_sel_e;

	// la sits in bit 0, same order as the target arrays
	typedef struct packed {
		logic as;
		logic is;
		logic up;
		logic aa;
		logic la;
	} tgt_en_t;

endpackage

`default_nettype wire

//--- source/cfg_ctrl_top.sv
`include "cfg_ctrl_config.svh"

`default_nettype none

module cfg_ctrl_top
	import cfg_ctrl_pkg::*;
(
	input  wire                       axi_clk,
	input  wire                       axi_reset_n,
	// wishbone slave
	input  wire wb_req_t              wb_req_i,
	output wb_rsp_t                   wb_rsp_o,
	// bridge axi-lite
	input  wire aa_req_t              aa_req_i,
	output aa_rsp_t                   aa_rsp_o,
	// master port and target responses
	output axil_req_t                 m_req_o,
	input  wire rd_resp_t             tgt_rd_resp_i [`CFG_NUM_TGT],
	input  wire wr_resp_t             tgt_wr_resp_i [`CFG_NUM_TGT],
	output tgt_en_t                   tgt_en_o,
	output logic [`CFG_PRJ_SEL_W-1:0] user_prj_sel_o
);

	logic                   grant_wb;
	logic                   grant_aa;
	logic [`CFG_ADDR_W-1:0] dec_araddr;
	logic [`CFG_ADDR_W-1:0] dec_awaddr;
	rd_resp_t               rd_resp;
	wr_resp_t               wr_resp;
	rd_resp_t               local_rd_resp;
	wr_resp_t               local_wr_resp;
	tgt_sel_e               wsel;
	tgt_en_t                rd_en;
	tgt_en_t                wr_en;

	// ------------------------------
	// request side
	// ------------------------------
	cfg_arbiter u_arbiter (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.wb_req_i    (wb_req_i),
		.aa_req_i    (aa_req_i),
		.aa_wready_i (aa_rsp_o.wready),
		.aa_rvalid_i (aa_rsp_o.rvalid),
		.grant_wb_o  (grant_wb),
		.grant_aa_o  (grant_aa)
	);

	cfg_master_mux u_master_mux (
		.axi_clk      (axi_clk),
		.axi_reset_n  (axi_reset_n),
		.grant_wb_i   (grant_wb),
		.grant_aa_i   (grant_aa),
		.wb_req_i     (wb_req_i),
		.aa_req_i     (aa_req_i),
		.rd_resp_i    (rd_resp),
		.wr_resp_i    (wr_resp),
		.m_req_o      (m_req_o),
		.dec_araddr_o (dec_araddr),
		.dec_awaddr_o (dec_awaddr),
		.wb_rsp_o     (wb_rsp_o),
		.aa_rsp_o     (aa_rsp_o)
	);

	// read channel routing
	cfg_target_route #(.resp_t(rd_resp_t)) u_rd_route (
		.axi_clk      (axi_clk),
		.axi_reset_n  (axi_reset_n),
		.addr_i       (dec_araddr),
		.tgt_resp_i   (tgt_rd_resp_i),
		.local_resp_i (local_rd_resp),
		.resp_o       (rd_resp),
		.sel_o        (),
		.tgt_en_o     (rd_en)
	);

	// write channel routing, its select feeds the local register
	cfg_target_route #(.resp_t(wr_resp_t)) u_wr_route (
		.axi_clk      (axi_clk),
		.axi_reset_n  (axi_reset_n),
		.addr_i       (dec_awaddr),
		.tgt_resp_i   (tgt_wr_resp_i),
		.local_resp_i (local_wr_resp),
		.resp_o       (wr_resp),
		.sel_o        (wsel),
		.tgt_en_o     (wr_en)
	);

	cfg_local_regs u_local_regs (
		.axi_clk        (axi_clk),
		.axi_reset_n    (axi_reset_n),
		.m_req_i        (m_req_o),
		.wsel_i         (wsel),
		.rd_resp_o      (local_rd_resp),
		.wr_resp_o      (local_wr_resp),
		.user_prj_sel_o (user_prj_sel_o)
	);

	// a target is enabled by either channel
	assign tgt_en_o = tgt_en_t'(rd_en | wr_en);

endmodule

`default_nettype wire

//--- source/cfg_local_regs.sv
`include "cfg_ctrl_config.svh"

`default_nettype none

module cfg_local_regs
	import cfg_ctrl_pkg::*;
(
	input  wire                       axi_clk,
	input  wire                       axi_reset_n,
	input  wire axil_req_t            m_req_i,
	input  wire tgt_sel_e             wsel_i,
	output rd_resp_t                  rd_resp_o,
	output wr_resp_t                  wr_resp_o,
	output logic [`CFG_PRJ_SEL_W-1:0] user_prj_sel_o
);

	logic prj_sel_we;

	// offset 0 of the local page, low byte enabled
	assign prj_sel_we = m_req_i.awvalid & m_req_i.wvalid & (wsel_i == TGT_LOCAL)
	                  & (m_req_i.awaddr[`CFG_PAGE_LSB-1:0] == '0) & m_req_i.wstrb[0];

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n)
			user_prj_sel_o <= '0;
		else if (prj_sel_we)
			user_prj_sel_o <= m_req_i.wdata[`CFG_PRJ_SEL_W-1:0];
	end

	// never stalls
	assign wr_resp_o.awready = 1'b1;
	assign wr_resp_o.wready  = 1'b1;
	assign rd_resp_o.arready = 1'b1;
	assign rd_resp_o.rvalid  = 1'b1;
	assign rd_resp_o.rdata   = {{(`CFG_DATA_W-`CFG_PRJ_SEL_W){1'b0}}, user_prj_sel_o};

endmodule

`default_nettype wire

//--- source/cfg_master_mux.sv
`include "cfg_ctrl_config.svh"

`default_nettype none

module cfg_master_mux
	import cfg_ctrl_pkg::*;
(
	input  wire                    axi_clk,
	input  wire                    axi_reset_n,
	input  wire                    grant_wb_i,
	input  wire                    grant_aa_i,
	input  wire wb_req_t           wb_req_i,
	input  wire aa_req_t           aa_req_i,
	input  wire rd_resp_t          rd_resp_i,
	input  wire wr_resp_t          wr_resp_i,
	output axil_req_t              m_req_o,
	output logic [`CFG_ADDR_W-1:0] dec_araddr_o,
	output logic [`CFG_ADDR_W-1:0] dec_awaddr_o,
	output wb_rsp_t                wb_rsp_o,
	output aa_rsp_t                aa_rsp_o
);

	logic wb_req;
	logic wb_w;
	logic wb_r;
	logic aa_w;
	logic aa_r;
	logic wb_awvalid_q;
	logic wb_arvalid_q;

	assign wb_req = wb_req_i.cyc & wb_req_i.stb;

	// granted wishbone write / read
	assign wb_w = grant_wb_i & wb_req_i.we & wb_req;
	assign wb_r = grant_wb_i & ~wb_req_i.we & wb_req;
	// granted bridge write / read
	assign aa_w = grant_aa_i & aa_req_i.wvalid;
	assign aa_r = grant_aa_i & aa_req_i.rready;

	// ------------------------------
	// address, data, strobes
	// ------------------------------
	// full address goes to the page decoders
	assign dec_awaddr_o = ({`CFG_ADDR_W{grant_wb_i}} & wb_req_i.adr)
	                    | ({`CFG_ADDR_W{grant_aa_i}} & aa_req_i.awaddr);
	assign dec_araddr_o = ({`CFG_ADDR_W{grant_wb_i}} & wb_req_i.adr)
	                    | ({`CFG_ADDR_W{grant_aa_i}} & aa_req_i.araddr);

	// master sees the low bits only
	assign m_req_o.awaddr = dec_awaddr_o[`CFG_M_ADDR_W-1:0];
	assign m_req_o.araddr = dec_araddr_o[`CFG_M_ADDR_W-1:0];
	assign m_req_o.wdata  = ({`CFG_DATA_W{grant_wb_i}} & wb_req_i.wdata)
	                      | ({`CFG_DATA_W{grant_aa_i}} & aa_req_i.wdata);
	assign m_req_o.wstrb  = ({`CFG_STRB_W{grant_wb_i}} & wb_req_i.sel)
	                      | ({`CFG_STRB_W{grant_aa_i}} & aa_req_i.wstrb);

	// wishbone address valids, up a cycle after grant, down after ready
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			wb_awvalid_q <= 1'b0;
			wb_arvalid_q <= 1'b0;
		end else begin
			wb_awvalid_q <= wb_w & ~wr_resp_i.awready;
			wb_arvalid_q <= wb_r & ~rd_resp_i.arready;
		end
	end

	// bridge valids pass straight through
	assign m_req_o.awvalid = (grant_wb_i & wb_awvalid_q) | (grant_aa_i & aa_req_i.awvalid);
	assign m_req_o.wvalid  = wb_w | aa_w;
	assign m_req_o.arvalid = (grant_wb_i & wb_arvalid_q) | (grant_aa_i & aa_req_i.arvalid);
	assign m_req_o.rready  = wb_r | aa_r;

	// ------------------------------
	// responses to the granted side
	// ------------------------------
	assign aa_rsp_o.awready = aa_w & wr_resp_i.awready;
	assign aa_rsp_o.wready  = aa_w & wr_resp_i.wready;
	assign aa_rsp_o.arready = aa_r & rd_resp_i.arready;
	assign aa_rsp_o.rvalid  = aa_r & rd_resp_i.rvalid;
	assign aa_rsp_o.rdata   = rd_resp_i.rdata;

	// ack is wvalid+wready on write, rvalid+rready on read
	assign wb_rsp_o.ack   = (wb_w & wr_resp_i.wready) | (wb_r & rd_resp_i.rvalid);
	assign wb_rsp_o.rdata = rd_resp_i.rdata;

endmodule

`default_nettype wire

//--- source/cfg_target_route.sv
`include "cfg_ctrl_config.svh"

`default_nettype none

module cfg_target_route
	import cfg_ctrl_pkg::*;
#(
	parameter type resp_t = logic
) (
	input  wire                   axi_clk,
	input  wire                   axi_reset_n,
	input  wire [`CFG_ADDR_W-1:0] addr_i,
	input  wire resp_t            tgt_resp_i [`CFG_NUM_TGT],
	input  wire resp_t            local_resp_i,
	output resp_t                 resp_o,
	output tgt_sel_e              sel_o,
	output tgt_en_t               tgt_en_o
);

	logic [`CFG_ADDR_W-`CFG_PAGE_LSB-1:0] page;
	tgt_sel_e                              sel_q;
	logic                                  sub_hit;

	assign page = addr_i[`CFG_ADDR_W-1:`CFG_PAGE_LSB];

	// page decode, one cycle behind the address
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			sel_q <= TGT_NONE;
		end else begin
			case (page)
				`CFG_PAGE_LA:    sel_q <= TGT_LA;
				`CFG_PAGE_AA:    sel_q <= TGT_AA;
				`CFG_PAGE_UP:    sel_q <= TGT_UP;
				`CFG_PAGE_IS:    sel_q <= TGT_IS;
				`CFG_PAGE_AS:    sel_q <= TGT_AS;
				`CFG_PAGE_LOCAL: sel_q <= TGT_LOCAL;
				default:         sel_q <= TGT_NONE;
			endcase
		end
	end

	// sub range answers in the same cycle
	assign sub_hit = (page >= `CFG_SUB_FIRST) && (page <= `CFG_SUB_LAST);
	assign sel_o   = sub_hit ? TGT_SUB : sel_q;

	always_comb begin
		case (sel_o)
			TGT_LA:    resp_o = tgt_resp_i[0];
			TGT_AA:    resp_o = tgt_resp_i[1];
			TGT_UP:    resp_o = tgt_resp_i[2];
			TGT_IS:    resp_o = tgt_resp_i[3];
			TGT_AS:    resp_o = tgt_resp_i[4];
			TGT_LOCAL: resp_o = local_resp_i;
			// all readies high, read data all ones
			TGT_SUB:   resp_o = '1;
			default:   resp_o = '0;
		endcase
	end

	// ------------------------------
	// target enables off the decode
	// ------------------------------
	assign tgt_en_o.la = (sel_q == TGT_LA);
	assign tgt_en_o.aa = (sel_q == TGT_AA);
	assign tgt_en_o.up = (sel_q == TGT_UP);
	assign tgt_en_o.is = (sel_q == TGT_IS);
	assign tgt_en_o.as = (sel_q == TGT_AS);

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/cfg_ctrl_pkg.sv
source/cfg_arbiter.sv
source/cfg_master_mux.sv
source/cfg_target_route.sv
source/cfg_local_regs.sv
source/cfg_ctrl_top.sv
dv/cfg_target_model.sv
dv/cfg_ctrl_tb.sv
